//--- Makefile
# Verilator build and run for the frame reflector

VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = eth_reflect_tb
FILELIST  = eth_reflect.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- eth_hdr_parser.sv
//////////////////////////////
// Header parser and filter
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "eth_reflect_consts.svh"

module eth_hdr_parser (
    input  wire                              clk,
    input  wire                              i_rst,
    input  wire                              i_valid,
    input  wire  [7:0]                       i_data,
    input  wire                              i_last,
    output logic                             o_wr,
    output eth_reflect_pkg::fifo_byte_t      o_wr_byte,
    output logic                             o_desc_valid,
    output eth_reflect_pkg::frame_desc_t     o_desc,
    output logic [15:0]                      o_runt_drops,
    output logic [15:0]                      o_filter_drops
);

    localparam logic [3:0] LAST_HDR_POS = 4'(`ETH_HDR_BYTES - 1);
    localparam logic [7:0] MAX_PAY_LEN  = 8'(`ETH_MAX_FRAME_BYTES - `ETH_HDR_BYTES);

    // P_TAIL discards bytes past the cap of an accepted frame,
    // P_DROP discards the rest of a filtered frame
    typedef enum logic [1:0] {P_HDR, P_PAY, P_TAIL, P_DROP} parse_state_t;

    parse_state_t               state;
    logic [3:0]                 pos;
    eth_reflect_pkg::eth_hdr_u  hdr_q;
    eth_reflect_pkg::eth_hdr_u  hdr_next;
    logic                       dst_match;
    logic                       cap_hit;

    function automatic logic [15:0] sat_inc(input logic [15:0] value);
        return (value == 16'hFFFF) ? value : value + 16'd1;
    endfunction

    // Header word including the byte arriving now
    always_comb begin
        hdr_next = hdr_q;
        hdr_next.bytes = {hdr_q.bytes[`ETH_HDR_BYTES-2:0], i_data};
    end

    assign dst_match = (hdr_next.fields.dst == `ETH_LOCAL_MAC) ||
                       (hdr_next.fields.dst == `ETH_BCAST_MAC);

    // Current payload byte is the last one that fits
    assign cap_hit = (o_desc.pay_len == MAX_PAY_LEN - 8'd1);

    //////////////////////////////
    // Control

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state          <= P_HDR;
            pos            <= '0;
            o_wr           <= 1'b0;
            o_desc_valid   <= 1'b0;
            o_runt_drops   <= '0;
            o_filter_drops <= '0;
        end else begin
            o_wr         <= 1'b0;
            o_desc_valid <= 1'b0;
            if (i_valid) begin
                case (state)
                    P_HDR: begin
                        if (pos == LAST_HDR_POS) begin
                            pos <= '0;
                            if (dst_match) begin
                                // Header-only frame goes out right away
                                if (i_last) begin
                                    o_desc_valid <= 1'b1;
                                end else begin
                                    state <= P_PAY;
                                end
                            end else begin
                                o_filter_drops <= sat_inc(o_filter_drops);
                                if (!i_last) begin
                                    state <= P_DROP;
                                end
                            end
                        end else if (i_last) begin
                            pos          <= '0;
                            o_runt_drops <= sat_inc(o_runt_drops);
                        end else begin
                            pos <= pos + 4'd1;
                        end
                    end
                    P_PAY: begin
                        o_wr <= 1'b1;
                        if (i_last) begin
                            o_desc_valid <= 1'b1;
                            state        <= P_HDR;
                        end else if (cap_hit) begin
                            state <= P_TAIL;
                        end
                    end
                    P_TAIL: begin
                        if (i_last) begin
                            o_desc_valid <= 1'b1;
                            state        <= P_HDR;
                        end
                    end
                    default: begin
                        if (i_last) begin
                            state <= P_HDR;
                        end
                    end
                endcase
            end
        end
    end

    //////////////////////////////
    // Header and payload data

    always_ff @(posedge clk) begin
        if (i_valid && state == P_HDR) begin
            hdr_q <= hdr_next;
            // Reply goes back to the sender, from this station
            if (pos == LAST_HDR_POS) begin
                o_desc.hdr.dst       <= hdr_next.fields.src;
                o_desc.hdr.src       <= `ETH_LOCAL_MAC;
                o_desc.hdr.ethertype <= hdr_next.fields.ethertype;
                o_desc.pay_len       <= '0;
            end
        end
        if (i_valid && state == P_PAY) begin
            o_wr_byte.data <= i_data;
            o_wr_byte.last <= i_last || cap_hit;
            o_desc.pay_len <= o_desc.pay_len + 8'd1;
        end
    end

endmodule

`default_nettype wire

//--- eth_hdr_writer.sv
//////////////////////////////
// Header writer and output
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "eth_reflect_consts.svh"

module eth_hdr_writer (
    input  wire                               clk,
    input  wire                               i_rst,
    input  wire                               i_desc_valid,
    input  wire eth_reflect_pkg::frame_desc_t i_desc,
    output logic                              o_rd,
    input  wire eth_reflect_pkg::fifo_byte_t  i_rd_byte,
    output logic                              o_valid,
    output logic [7:0]                        o_data,
    output logic                              o_last
);

    localparam int         QW        = $clog2(`ETH_DESC_DEPTH);
    localparam logic [3:0] FIRST_IDX = 4'(`ETH_HDR_BYTES - 2);

    typedef enum logic [1:0] {W_IDLE, W_LOAD, W_HDR, W_PAY} write_state_t;

    eth_reflect_pkg::frame_desc_t desc_mem [`ETH_DESC_DEPTH];

    logic [QW-1:0]              q_wr_ptr;
    logic [QW-1:0]              q_rd_ptr;
    logic [QW:0]                q_count;
    logic                       q_pop;
    logic                       desc_ready;
    write_state_t               state;
    eth_reflect_pkg::eth_hdr_u  head_u;
    eth_reflect_pkg::eth_hdr_u  cur_hdr;
    logic [7:0]                 cur_len;
    logic [3:0]                 hdr_idx;
    logic [7:0]                 rd_left;
    logic                       rd_pend;

    // Head of the descriptor queue seen as bytes
    always_comb begin
        head_u.fields = desc_mem[q_rd_ptr].hdr;
    end

    assign q_pop = (state == W_LOAD);

    // A descriptor pushed this cycle is readable in the next one
    assign desc_ready = (q_count != '0) || i_desc_valid;

    // Reads start with the last header byte so payload follows without a gap
    always_comb begin
        o_rd = 1'b0;
        if (state == W_HDR && hdr_idx == '0 && cur_len != '0) begin
            o_rd = 1'b1;
        end else if (state == W_PAY && rd_left != '0) begin
            o_rd = 1'b1;
        end
    end

    //////////////////////////////
    // Queue and FSM

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state    <= W_IDLE;
            q_wr_ptr <= '0;
            q_rd_ptr <= '0;
            q_count  <= '0;
            hdr_idx  <= '0;
            rd_left  <= '0;
            rd_pend  <= 1'b0;
            o_valid  <= 1'b0;
            o_last   <= 1'b0;
        end else begin
            o_valid <= 1'b0;
            o_last  <= 1'b0;
            rd_pend <= o_rd;
            if (i_desc_valid) begin
                q_wr_ptr <= q_wr_ptr + QW'(1);
            end
            if (q_pop) begin
                q_rd_ptr <= q_rd_ptr + QW'(1);
            end
            q_count <= q_count + (QW+1)'(i_desc_valid) - (QW+1)'(q_pop);
            case (state)
                W_IDLE: begin
                    if (desc_ready) begin
                        state <= W_LOAD;
                    end
                end
                // First header byte leaves while the descriptor is taken
                W_LOAD: begin
                    o_valid <= 1'b1;
                    hdr_idx <= FIRST_IDX;
                    state   <= W_HDR;
                end
                W_HDR: begin
                    o_valid <= 1'b1;
                    if (hdr_idx == '0) begin
                        if (cur_len == '0) begin
                            o_last <= 1'b1;
                            state  <= desc_ready ? W_LOAD : W_IDLE;
                        end else begin
                            rd_left <= cur_len - 8'd1;
                            state   <= W_PAY;
                        end
                    end else begin
                        hdr_idx <= hdr_idx - 4'd1;
                    end
                end
                default: begin
                    if (rd_left != '0) begin
                        rd_left <= rd_left - 8'd1;
                    end
                    if (rd_pend) begin
                        o_valid <= 1'b1;
                        o_last  <= i_rd_byte.last;
                        if (i_rd_byte.last) begin
                            state <= desc_ready ? W_LOAD : W_IDLE;
                        end
                    end
                end
            endcase
        end
    end

    //////////////////////////////
    // Data path

    always_ff @(posedge clk) begin
        if (i_desc_valid) begin
            desc_mem[q_wr_ptr] <= i_desc;
        end
        if (state == W_LOAD) begin
            cur_hdr <= head_u;
            cur_len <= desc_mem[q_rd_ptr].pay_len;
            o_data  <= head_u.bytes[`ETH_HDR_BYTES-1];
        end else if (state == W_HDR) begin
            o_data <= cur_hdr.bytes[hdr_idx];
        end else if (state == W_PAY) begin
            o_data <= i_rd_byte.data;
        end
    end

endmodule

`default_nettype wire

//--- eth_reflect.f
+incdir+.
eth_reflect_pkg.sv
pkt_byte_fifo.sv
eth_hdr_parser.sv
eth_hdr_writer.sv
eth_reflect_top.sv
eth_reflect_tb.sv

//--- eth_reflect_consts.svh
//////////////////////////////
// Frame reflector constants
//////////////////////////////

`ifndef ETH_REFLECT_CONSTS_SVH
`define ETH_REFLECT_CONSTS_SVH

//////////////////////////////
// Frame geometry

// Destination, source and ethertype
`define ETH_HDR_BYTES 14

// Longer frames are cut here, header included
`define ETH_MAX_FRAME_BYTES 100

//////////////////////////////
// Buffering

// Payload byte entries, power of two
`define ETH_FIFO_DEPTH 256

// Pending frames waiting for the writer
`define ETH_DESC_DEPTH 4

//////////////////////////////
// Station addresses

`define ETH_LOCAL_MAC 48'hAA_BB_CC_DD_EE_FF
`define ETH_BCAST_MAC 48'hFF_FF_FF_FF_FF_FF

`endif

//--- eth_reflect_pkg.sv
//////////////////////////////
// Frame reflector types
//////////////////////////////

`default_nettype none

`include "eth_reflect_consts.svh"

package eth_reflect_pkg;

    typedef logic [47:0] mac_addr_t;

    // Field order follows the wire order, first byte in the top bits
    typedef struct packed {
        mac_addr_t   dst;
        mac_addr_t   src;
        logic [15:0] ethertype;
    } eth_hdr_t;

    // Filled as raw bytes, read back as fields
    // bytes[13] is the first byte on the wire
    typedef union packed {
        eth_hdr_t                             fields;
        logic [`ETH_HDR_BYTES-1:0][7:0]       bytes;
    } eth_hdr_u;

    // One entry per accepted frame, header already rewritten
    typedef struct packed {
        eth_hdr_t   hdr;
        logic [7:0] pay_len;
    } frame_desc_t;

    // Payload byte plus end of frame marker
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } fifo_byte_t;

endpackage

`default_nettype wire

//--- eth_reflect_tb.sv
//////////////////////////////
// Frame reflector testbench
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "eth_reflect_consts.svh"

module eth_reflect_tb;

    localparam int NUM_ROWS   = 10;
    localparam int HDR        = `ETH_HDR_BYTES;
    localparam int MAX_FRAME  = `ETH_MAX_FRAME_BYTES;
    localparam int ROW_CYCLES = 2 * MAX_FRAME + 20;

    localparam logic [1:0] CLS_REFLECT = 2'd0;
    localparam logic [1:0] CLS_RUNT    = 2'd1;
    localparam logic [1:0] CLS_FILTER  = 2'd2;

    localparam eth_reflect_pkg::mac_addr_t PEER_A = 48'h02_11_22_33_44_55;
    localparam eth_reflect_pkg::mac_addr_t PEER_B = 48'h02_66_77_88_99_AA;
    localparam eth_reflect_pkg::mac_addr_t OTHER  = 48'h02_00_00_00_00_99;

    // One stimulus row with the class that decides what comes out
    typedef struct packed {
        eth_reflect_pkg::mac_addr_t dst;
        eth_reflect_pkg::mac_addr_t src;
        logic [15:0]                ethertype;
        logic [7:0]                 len;
        logic [1:0]                 cls;
    } row_t;

    logic        clk;
    logic        i_rst;
    logic        i_valid;
    logic [7:0]  i_data;
    logic        i_last;
    logic        o_valid;
    logic [7:0]  o_data;
    logic        o_last;
    logic [15:0] o_runt_drops;
    logic [15:0] o_filter_drops;

    row_t rows [NUM_ROWS];

    // Expected frames in output order
    eth_reflect_pkg::eth_hdr_t exp_hdr_q [$];
    int                        exp_len_q [$];
    int                        exp_row_q [$];
    logic [7:0]                exp_pay_q [$];

    logic [7:0]  stim_q [$];
    logic [7:0]  got_q [$];
    logic [15:0] exp_runt;
    logic [15:0] exp_filter;
    int          error_count;
    int          tests_passed;
    int          tests_failed;

    eth_reflect_top uut (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_valid        (i_valid),
        .i_data         (i_data),
        .i_last         (i_last),
        .o_valid        (o_valid),
        .o_data         (o_data),
        .o_last         (o_last),
        .o_runt_drops   (o_runt_drops),
        .o_filter_drops (o_filter_drops)
    );

    always #10 clk = ~clk;

    //////////////////////////////
    // Stimulus table

    function automatic void fill_rows();
        rows[0] = '{dst: `ETH_LOCAL_MAC, src: PEER_A, ethertype: 16'h0800, len: 8'd64,
                    cls: CLS_REFLECT};
        rows[1] = '{dst: `ETH_BCAST_MAC, src: PEER_B, ethertype: 16'h0806, len: 8'd40,
                    cls: CLS_REFLECT};
        // Cut at the frame cap
        rows[2] = '{dst: `ETH_LOCAL_MAC, src: PEER_B, ethertype: 16'h86DD, len: 8'd150,
                    cls: CLS_REFLECT};
        rows[3] = '{dst: `ETH_LOCAL_MAC, src: PEER_A, ethertype: 16'h88B5, len: 8'd14,
                    cls: CLS_REFLECT};
        rows[4] = '{dst: OTHER, src: PEER_A, ethertype: 16'h0800, len: 8'd50,
                    cls: CLS_FILTER};
        rows[5] = '{dst: `ETH_LOCAL_MAC, src: PEER_B, ethertype: 16'h0800, len: 8'd6,
                    cls: CLS_RUNT};
        rows[6] = '{dst: `ETH_LOCAL_MAC, src: PEER_B, ethertype: 16'h0842, len: 8'd20,
                    cls: CLS_REFLECT};
        rows[7] = '{dst: `ETH_BCAST_MAC, src: PEER_A, ethertype: 16'h0800, len: 8'd100,
                    cls: CLS_REFLECT};
        rows[8] = '{dst: OTHER, src: PEER_B, ethertype: 16'h0806, len: 8'd14,
                    cls: CLS_FILTER};
        rows[9] = '{dst: `ETH_LOCAL_MAC, src: PEER_A, ethertype: 16'h9000, len: 8'd15,
                    cls: CLS_REFLECT};
    endfunction

    //////////////////////////////
    // Compare tasks

    task automatic check_hdr(input eth_reflect_pkg::eth_hdr_t got,
                             input eth_reflect_pkg::eth_hdr_t exp, inout int fails);
        if (got !== exp) begin
            $display("ERROR %0t: header got dst %h src %h type %h", $time,
                     got.dst, got.src, got.ethertype);
            $display("    expected dst %h src %h type %h", exp.dst, exp.src, exp.ethertype);
            error_count++;
            fails++;
        end
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input int idx,
                              inout int fails);
        if (got !== exp) begin
            $display("ERROR %0t: payload byte %0d got %h expected %h", $time, idx, got, exp);
            error_count++;
            fails++;
        end
    endtask

    task automatic check_len(input int got, input int exp, inout int fails);
        if (got != exp) begin
            $display("ERROR %0t: frame length got %0d expected %0d", $time, got, exp);
            error_count++;
            fails++;
        end
    endtask

    task automatic check_counter(input logic [15:0] got, input logic [15:0] exp,
                                 input string name, inout int fails);
        if (got !== exp) begin
            $display("ERROR %0t: %s drop counter got %0d expected %0d", $time, name, got, exp);
            error_count++;
            fails++;
        end
    endtask

    task automatic report_test(input int idx, input string kind, input int fails);
        if (fails == 0) begin
            tests_passed++;
            $display("Test %0d %s: ok", idx, kind);
        end else begin
            tests_failed++;
            $display("Test %0d %s: FAILED with %0d mismatches", idx, kind, fails);
        end
    endtask

    //////////////////////////////
    // Reference model

    // Reply goes to the sender from the local station with the payload cut at the cap
    task automatic predict_reflection(input row_t r, input int idx);
        eth_reflect_pkg::eth_hdr_t hdr;
        int                        kept;
        int                        i;
        kept = int'(r.len);
        if (kept > MAX_FRAME) begin
            kept = MAX_FRAME;
        end
        hdr.dst       = r.src;
        hdr.src       = `ETH_LOCAL_MAC;
        hdr.ethertype = r.ethertype;
        exp_hdr_q.push_back(hdr);
        exp_len_q.push_back(kept - HDR);
        exp_row_q.push_back(idx);
        for (i = HDR; i < kept; i++) begin
            exp_pay_q.push_back(stim_q[i]);
        end
    endtask

    //////////////////////////////
    // Driver

    task automatic send_frame(input row_t r, input int idx);
        logic [111:0] hdr_bits;
        int           len;
        int           i;
        len      = int'(r.len);
        hdr_bits = {r.dst, r.src, r.ethertype};
        stim_q.delete();
        for (i = 0; i < len; i++) begin
            if (i < HDR) begin
                stim_q.push_back(hdr_bits[111 - 8 * i -: 8]);
            end else begin
                stim_q.push_back(8'($urandom));
            end
        end
        if (r.cls == CLS_REFLECT) begin
            predict_reflection(r, idx);
        end
        for (i = 0; i < len; i++) begin
            @(posedge clk);
            i_valid <= 1'b1;
            i_data  <= stim_q[i];
            i_last  <= (i == len - 1);
        end
        // Two idle cycles before the next frame
        @(posedge clk);
        i_valid <= 1'b0;
        i_data  <= 8'h00;
        i_last  <= 1'b0;
        @(posedge clk);
    endtask

    task automatic check_drop(input row_t r, input int idx);
        int    fails;
        string kind;
        fails = 0;
        if (r.cls == CLS_RUNT) begin
            exp_runt = exp_runt + 16'd1;
            kind     = "runt drop";
        end else begin
            exp_filter = exp_filter + 16'd1;
            kind       = "filter drop";
        end
        check_counter(o_runt_drops, exp_runt, "runt", fails);
        check_counter(o_filter_drops, exp_filter, "filter", fails);
        report_test(idx, kind, fails);
    endtask

    //////////////////////////////
    // Monitor

    task automatic compare_frame();
        logic [111:0] hdr_bits;
        logic [7:0]   exp_b;
        int           plen;
        int           row;
        int           fails;
        int           i;
        fails = 0;
        if (exp_len_q.size() == 0) begin
            $display("Unexpected extra frame of %0d bytes at %0t", got_q.size(), $time);
            error_count++;
            return;
        end
        plen     = exp_len_q.pop_front();
        row      = exp_row_q.pop_front();
        hdr_bits = '0;
        for (i = 0; i < HDR && i < got_q.size(); i++) begin
            hdr_bits = {hdr_bits[103:0], got_q[i]};
        end
        check_hdr(eth_reflect_pkg::eth_hdr_t'(hdr_bits), exp_hdr_q.pop_front(), fails);
        check_len(got_q.size(), HDR + plen, fails);
        for (i = 0; i < plen; i++) begin
            exp_b = exp_pay_q.pop_front();
            if (HDR + i < got_q.size()) begin
                check_byte(got_q[HDR + i], exp_b, i, fails);
            end
        end
        report_test(row, "reflect", fails);
    endtask

    // o_last closes the frame collected so far
    always @(posedge clk) begin
        if (!i_rst && o_valid === 1'b1) begin
            got_q.push_back(o_data);
            if (o_last === 1'b1) begin
                compare_frame();
                got_q.delete();
            end
        end
    end

    //////////////////////////////
    // Main sequence

    initial begin
        int r;
        int wait_cycles;
        void'($urandom(41));
        clk          = 1'b0;
        i_rst        = 1'b1;
        i_valid      = 1'b0;
        i_data       = 8'h00;
        i_last       = 1'b0;
        exp_runt     = '0;
        exp_filter   = '0;
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        fill_rows();
        repeat (4) @(posedge clk);
        i_rst <= 1'b0;
        for (r = 0; r < NUM_ROWS; r++) begin
            send_frame(rows[r], r);
            if (rows[r].cls != CLS_REFLECT) begin
                check_drop(rows[r], r);
            end
        end
        wait_cycles = 0;
        while (exp_len_q.size() != 0 && wait_cycles < ROW_CYCLES) begin
            @(posedge clk);
            wait_cycles++;
        end
        // Quiet period to catch a stray frame
        repeat (20) @(posedge clk);
        while (exp_row_q.size() != 0) begin
            $display("Frame for test %0d never came out of the DUT", exp_row_q.pop_front());
            error_count++;
            tests_failed++;
        end
        $display("Summary: %0d tests passed, %0d tests failed, %0d check errors",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        repeat (NUM_ROWS * ROW_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not complete",
                 NUM_ROWS * ROW_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- eth_reflect_top.sv
//////////////////////////////
// Frame reflector top
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "eth_reflect_consts.svh"

module eth_reflect_top (
    input  wire          clk,
    input  wire          i_rst,
    input  wire          i_valid,
    input  wire  [7:0]   i_data,
    input  wire          i_last,
    output logic         o_valid,
    output logic [7:0]   o_data,
    output logic         o_last,
    output logic [15:0]  o_runt_drops,
    output logic [15:0]  o_filter_drops
);

    logic                          fifo_wr;
    eth_reflect_pkg::fifo_byte_t   fifo_wr_byte;
    logic                          fifo_rd;
    eth_reflect_pkg::fifo_byte_t   fifo_rd_byte;
    logic                          desc_valid;
    eth_reflect_pkg::frame_desc_t  desc;

    // Input side, header capture and filtering
    eth_hdr_parser parser_i (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_valid        (i_valid),
        .i_data         (i_data),
        .i_last         (i_last),
        .o_wr           (fifo_wr),
        .o_wr_byte      (fifo_wr_byte),
        .o_desc_valid   (desc_valid),
        .o_desc         (desc),
        .o_runt_drops   (o_runt_drops),
        .o_filter_drops (o_filter_drops)
    );

    pkt_byte_fifo #(
        .DEPTH (`ETH_FIFO_DEPTH)
    ) fifo_i (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_wr      (fifo_wr),
        .i_wr_byte (fifo_wr_byte),
        .i_rd      (fifo_rd),
        .o_rd_byte (fifo_rd_byte)
    );

    // Output side, rewritten header then buffered payload
    eth_hdr_writer writer_i (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_desc_valid (desc_valid),
        .i_desc       (desc),
        .o_rd         (fifo_rd),
        .i_rd_byte    (fifo_rd_byte),
        .o_valid      (o_valid),
        .o_data       (o_data),
        .o_last       (o_last)
    );

endmodule

`default_nettype wire

//--- pkt_byte_fifo.sv
//////////////////////////////
// Payload byte FIFO
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module pkt_byte_fifo #(
    parameter int DEPTH = 256
) (
    input  wire                              clk,
    input  wire                              i_rst,
    input  wire                              i_wr,
    input  wire eth_reflect_pkg::fifo_byte_t i_wr_byte,
    input  wire                              i_rd,
    output eth_reflect_pkg::fifo_byte_t      o_rd_byte
);

    localparam int AW = $clog2(DEPTH);

    eth_reflect_pkg::fifo_byte_t mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;

    //////////////////////////////
    // Pointers

    // Both wrap naturally at DEPTH
    always_ff @(posedge clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (i_wr) begin
                wr_ptr <= wr_ptr + AW'(1);
            end
            if (i_rd) begin
                rd_ptr <= rd_ptr + AW'(1);
            end
        end
    end

    //////////////////////////////
    // Storage

    always_ff @(posedge clk) begin
        if (i_wr) begin
            mem[wr_ptr] <= i_wr_byte;
        end
    end

    // Registered read port, data one cycle after the strobe
    // The writer only reads bytes whose descriptor has arrived,
    // so a read never targets the slot being written
    always_ff @(posedge clk) begin
        if (i_rd) begin
            o_rd_byte <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire
